// File: source/cachePkg.sv
`default_nettype none

package cachePkg;

  // geometry of the cache, fixed for the core
  localparam int wayCount   = 2;  // one LRU bit per set only covers two ways
  localparam int wayBits    = $clog2(wayCount);
  localparam int offsetBits = 2;  // byte offset inside a word
  localparam int addrWidth  = 32;
  localparam int dataWidth  = 32;
  localparam int byteWidth  = 8;
  localparam int laneCount  = dataWidth / byteWidth;

  // request opcodes from the memory stage
  typedef enum logic {
    opLoad,   // lbu
    opStore   // sb
  } cacheOp_e;

  // controller sequencing
  typedef enum logic [1:0] {
    stIdle,
    stLookup,   // tag compare on the registered request
    stFill,     // waiting on the backing memory
    stRespond   // strobes out, back to idle next
  } ctrlState_e;

endpackage

`default_nettype wire

// File: source/cacheWay.sv
`timescale 1ns/100ps
`default_nettype none

module cacheWay #(
  parameter int setBits = 3
) (
  input  wire logic                           clk,
  input  wire logic                           arstN,
  input  wire logic [setBits-1:0]             lookupSet,
  input  wire logic [cachePkg::addrWidth-setBits-cachePkg::offsetBits-1:0] lookupTag,
  input  wire logic                           wayEn,     // this way is the fill/write target
  input  wire logic                           fillEn,
  input  wire logic [cachePkg::dataWidth-1:0] fillData,
  input  wire logic                           byteWrEn,
  input  wire logic [cachePkg::offsetBits-1:0] byteLane,
  input  wire logic [cachePkg::byteWidth-1:0] byteData,
  output logic                                wayHit,
  output logic [cachePkg::dataWidth-1:0]      wayData
);

  localparam int tagBits = cachePkg::addrWidth - setBits - cachePkg::offsetBits;
  localparam int nSets   = 2 ** setBits;

  logic [nSets-1:0]               validBits;
  logic [tagBits-1:0]             tagArr  [nSets];
  logic [cachePkg::dataWidth-1:0] dataArr [nSets];

  logic doFill;
  logic doByteWr;

  assign doFill   = fillEn & wayEn;
  assign doByteWr = byteWrEn & wayEn;

  // a set turns valid on its first fill
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validBits <= '0;
    end else if (doFill) begin
      validBits[lookupSet] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (doFill) begin
      tagArr[lookupSet]  <= lookupTag;
      dataArr[lookupSet] <= fillData;
    end else if (doByteWr) begin
      // only the addressed lane changes
      dataArr[lookupSet][byteLane*cachePkg::byteWidth +: cachePkg::byteWidth] <= byteData;
    end
  end

  // combinational compare on the current lookup
  assign wayHit  = validBits[lookupSet] && (tagArr[lookupSet] == lookupTag);
  assign wayData = dataArr[lookupSet];

endmodule

`default_nettype wire

// File: source/wayMerge.sv
`timescale 1ns/100ps
`default_nettype none

module wayMerge #(
  parameter int setBits = 3
) (
  input  wire logic                                                  clk,
  input  wire logic                                                  arstN,
  input  wire logic [cachePkg::wayCount-1:0]                         wayHitVec,
  input  wire logic [cachePkg::wayCount-1:0][cachePkg::dataWidth-1:0] wayDataVec,
  input  wire logic [setBits-1:0]                                    lookupSet,
  input  wire logic                                                  lruTouch,
  input  wire logic [cachePkg::wayBits-1:0]                          touchWay,
  output logic                                                       anyHit,
  output logic [cachePkg::wayBits-1:0]                               hitWay,
  output logic [cachePkg::dataWidth-1:0]                             lineData,
  output logic [cachePkg::wayBits-1:0]                               victimWay
);

  localparam int nSets = 2 ** setBits;

  // per set, the way that was touched most recently
  logic [nSets-1:0] lruBits;

  assign anyHit = |wayHitVec;

  // at most one way hits, so a priority scan is enough
  always_comb begin
    hitWay = '0;
    for (int w = 0; w < cachePkg::wayCount; w++) begin
      if (wayHitVec[w]) begin
        hitWay = cachePkg::wayBits'(w);
      end
    end
  end

  assign lineData = wayDataVec[hitWay];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lruBits <= '0;
    end else if (lruTouch) begin
      lruBits[lookupSet] <= touchWay;
    end
  end

  // two ways, so the victim is simply the other one
  assign victimWay = ~lruBits[lookupSet];

endmodule

`default_nettype wire

// File: source/cacheCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module cacheCtrl #(
  parameter int setBits = 3
) (
  input  wire logic                            clk,
  input  wire logic                            arstN,
  // request side
  input  wire logic                            reqValid,
  input  wire cachePkg::cacheOp_e              reqOp,
  input  wire logic [cachePkg::addrWidth-1:0]  reqAddr,
  input  wire logic [cachePkg::dataWidth-1:0]  reqData,
  output logic                                 respValid,
  output logic [cachePkg::dataWidth-1:0]       respData,
  output logic                                 respHit,
  // from the merge block
  input  wire logic                            anyHit,
  input  wire logic [cachePkg::wayBits-1:0]    hitWay,
  input  wire logic [cachePkg::dataWidth-1:0]  lineData,
  input  wire logic [cachePkg::wayBits-1:0]    victimWay,
  // broadcast to the ways
  output logic [setBits-1:0]                   lookupSet,
  output logic [cachePkg::addrWidth-setBits-cachePkg::offsetBits-1:0] lookupTag,
  output logic                                 fillEn,
  output logic [cachePkg::wayBits-1:0]         fillWay,
  output logic [cachePkg::dataWidth-1:0]       fillData,
  output logic                                 byteWrEn,
  output logic [cachePkg::offsetBits-1:0]      byteLane,
  output logic [cachePkg::byteWidth-1:0]       byteData,
  output logic                                 lruTouch,
  output logic [cachePkg::wayBits-1:0]         touchWay,
  // backing memory
  output logic                                 memRead,
  output logic                                 memWrite,
  output logic [cachePkg::addrWidth-cachePkg::offsetBits-1:0] memAddr,
  output logic [cachePkg::offsetBits-1:0]      memLane,
  output logic [cachePkg::dataWidth-1:0]       memWrData,
  input  wire logic                            memReadValid,
  input  wire logic [cachePkg::dataWidth-1:0]  memRdData
);

  localparam int tagBits = cachePkg::addrWidth - setBits - cachePkg::offsetBits;
  localparam int padBits = cachePkg::dataWidth - cachePkg::byteWidth;

  cachePkg::ctrlState_e state;

  cachePkg::cacheOp_e              opReg;
  logic [cachePkg::addrWidth-1:0]  addrReg;
  logic [cachePkg::byteWidth-1:0]  byteReg;   // store byte
  logic [cachePkg::wayBits-1:0]    selWay;    // hit way, or victim on a miss
  logic [cachePkg::offsetBits-1:0] offset;

  assign offset    = addrReg[cachePkg::offsetBits-1:0];
  assign lookupSet = addrReg[cachePkg::offsetBits +: setBits];
  assign lookupTag = addrReg[cachePkg::addrWidth-1 -: tagBits];

  assign byteLane  = offset;
  assign byteData  = byteReg;
  assign fillWay   = selWay;
  assign touchWay  = selWay;
  assign memAddr   = addrReg[cachePkg::addrWidth-1:cachePkg::offsetBits];
  assign memLane   = offset;
  assign memWrData = {cachePkg::laneCount{byteReg}};  // lane picked by memLane

  // sequencing and one-cycle strobes
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state     <= cachePkg::stIdle;
      respValid <= 1'b0;
      memRead   <= 1'b0;
      memWrite  <= 1'b0;
      fillEn    <= 1'b0;
      byteWrEn  <= 1'b0;
      lruTouch  <= 1'b0;
    end else begin
      respValid <= 1'b0;
      memRead   <= 1'b0;
      memWrite  <= 1'b0;
      fillEn    <= 1'b0;
      byteWrEn  <= 1'b0;
      lruTouch  <= 1'b0;
      case (state)
        cachePkg::stIdle: begin
          if (reqValid) state <= cachePkg::stLookup;
        end
        cachePkg::stLookup: begin
          if (opReg == cachePkg::opStore) begin
            memWrite  <= 1'b1;    // write-through, no allocate on miss
            byteWrEn  <= anyHit;
            lruTouch  <= anyHit;
            respValid <= 1'b1;
            state     <= cachePkg::stRespond;
          end else if (anyHit) begin
            lruTouch  <= 1'b1;
            respValid <= 1'b1;
            state     <= cachePkg::stRespond;
          end else begin
            memRead <= 1'b1;
            state   <= cachePkg::stFill;
          end
        end
        cachePkg::stFill: begin
          if (memReadValid) begin
            fillEn    <= 1'b1;
            lruTouch  <= 1'b1;    // refilled line becomes most recent
            respValid <= 1'b1;
            state     <= cachePkg::stRespond;
          end
        end
        default: state <= cachePkg::stIdle;  // stRespond
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge clk) begin
    if (state == cachePkg::stIdle && reqValid) begin
      opReg   <= reqOp;
      addrReg <= reqAddr;
      byteReg <= reqData[cachePkg::byteWidth-1:0];
    end
    if (state == cachePkg::stLookup) begin
      selWay  <= anyHit ? hitWay : victimWay;
      respHit <= anyHit;
      if (opReg == cachePkg::opLoad) begin
        respData <= {{padBits{1'b0}}, lineData[offset*cachePkg::byteWidth +: cachePkg::byteWidth]};
      end else begin
        respData <= '0;
      end
    end
    if (state == cachePkg::stFill && memReadValid) begin
      fillData <= memRdData;
      respHit  <= 1'b0;
      respData <= {{padBits{1'b0}}, memRdData[offset*cachePkg::byteWidth +: cachePkg::byteWidth]};
    end
  end

endmodule

`default_nettype wire

// File: source/mainMemory.sv
`timescale 1ns/100ps
`default_nettype none

module mainMemory #(
  parameter int memLatency  = 4,
  parameter int memWordBits = 10
) (
  input  wire logic                            clk,
  input  wire logic                            arstN,
  input  wire logic                            memRead,
  input  wire logic                            memWrite,
  input  wire logic [memWordBits-1:0]          memAddr,
  input  wire logic [cachePkg::offsetBits-1:0] memLane,
  input  wire logic [cachePkg::dataWidth-1:0]  memWrData,
  output logic                                 memReadValid,
  output logic [cachePkg::dataWidth-1:0]       memRdData
);

  localparam int memWords = 2 ** memWordBits;

  logic [cachePkg::dataWidth-1:0] memArr [memWords];

  // read strobes and addresses in flight, one stage per cycle
  logic [memLatency-1:0]                  rdValidPipe;
  logic [memLatency-1:0][memWordBits-1:0] rdAddrPipe;

  initial begin
    for (int i = 0; i < memWords; i++) begin
      memArr[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (memWrite) begin
      memArr[memAddr][memLane*cachePkg::byteWidth +: cachePkg::byteWidth] <=
        memWrData[memLane*cachePkg::byteWidth +: cachePkg::byteWidth];
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rdValidPipe <= '0;
    end else begin
      rdValidPipe[0] <= memRead;
      for (int i = 1; i < memLatency; i++) begin
        rdValidPipe[i] <= rdValidPipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    rdAddrPipe[0] <= memAddr;
    for (int i = 1; i < memLatency; i++) begin
      rdAddrPipe[i] <= rdAddrPipe[i-1];
    end
  end

  // data is read out of the array in the last stage
  assign memReadValid = rdValidPipe[memLatency-1];
  assign memRdData    = memArr[rdAddrPipe[memLatency-1]];

endmodule

`default_nettype wire

// File: source/dataCache.sv
`timescale 1ns/100ps
`default_nettype none

module dataCache #(
  parameter int setBits     = 3,
  parameter int memLatency  = 4,
  parameter int memWordBits = 10
) (
  input  wire logic                           clk,
  input  wire logic                           arstN,
  input  wire logic                           reqValid,
  input  wire cachePkg::cacheOp_e             reqOp,
  input  wire logic [cachePkg::addrWidth-1:0] reqAddr,
  input  wire logic [cachePkg::dataWidth-1:0] reqData,
  output logic                                respValid,
  output logic [cachePkg::dataWidth-1:0]      respData,
  output logic                                respHit
);

  localparam int tagBits = cachePkg::addrWidth - setBits - cachePkg::offsetBits;

  // controller to ways
  logic [setBits-1:0]              lookupSet;
  logic [tagBits-1:0]              lookupTag;
  logic                            fillEn;
  logic [cachePkg::wayBits-1:0]    fillWay;
  logic [cachePkg::dataWidth-1:0]  fillData;
  logic                            byteWrEn;
  logic [cachePkg::offsetBits-1:0] byteLane;
  logic [cachePkg::byteWidth-1:0]  byteData;

  // ways to merge, merge to controller
  logic [cachePkg::wayCount-1:0]                          wayHitVec;
  logic [cachePkg::wayCount-1:0][cachePkg::dataWidth-1:0] wayDataVec;
  logic                            anyHit;
  logic [cachePkg::wayBits-1:0]    hitWay;
  logic [cachePkg::dataWidth-1:0]  lineData;
  logic [cachePkg::wayBits-1:0]    victimWay;
  logic                            lruTouch;
  logic [cachePkg::wayBits-1:0]    touchWay;

  // controller to memory
  logic                            memRead;
  logic                            memWrite;
  logic [cachePkg::addrWidth-cachePkg::offsetBits-1:0] memAddr;
  logic [cachePkg::offsetBits-1:0] memLane;
  logic [cachePkg::dataWidth-1:0]  memWrData;
  logic                            memReadValid;
  logic [cachePkg::dataWidth-1:0]  memRdData;

  cacheCtrl #(.setBits(setBits)) ctrl (
    .clk, .arstN,
    .reqValid, .reqOp, .reqAddr, .reqData,
    .respValid, .respData, .respHit,
    .anyHit, .hitWay, .lineData, .victimWay,
    .lookupSet, .lookupTag, .fillEn, .fillWay, .fillData,
    .byteWrEn, .byteLane, .byteData, .lruTouch, .touchWay,
    .memRead, .memWrite, .memAddr, .memLane, .memWrData,
    .memReadValid, .memRdData
  );

  for (genvar w = 0; w < cachePkg::wayCount; w++) begin : gWay
    logic wayEn;
    assign wayEn = (fillWay == cachePkg::wayBits'(w));

    cacheWay #(.setBits(setBits)) way (
      .clk, .arstN, .lookupSet, .lookupTag, .wayEn,
      .fillEn, .fillData, .byteWrEn, .byteLane, .byteData,
      .wayHit  (wayHitVec[w]),
      .wayData (wayDataVec[w])
    );
  end

  wayMerge #(.setBits(setBits)) merge (
    .clk, .arstN, .wayHitVec, .wayDataVec, .lookupSet,
    .lruTouch, .touchWay, .anyHit, .hitWay, .lineData, .victimWay
  );

  mainMemory #(.memLatency(memLatency), .memWordBits(memWordBits)) mem (
    .clk, .arstN, .memRead, .memWrite,
    .memAddr (memAddr[memWordBits-1:0]),  // upper word bits alias
    .memLane, .memWrData, .memReadValid, .memRdData
  );

endmodule

`default_nettype wire

// File: tb/dataCacheTb.sv
`timescale 1ns/100ps
`default_nettype none

module dataCacheTb;

  localparam int setBits     = 3;
  localparam int memLatency  = 4;
  localparam int memWordBits = 10;
  localparam int tagBits     = cachePkg::addrWidth - setBits - cachePkg::offsetBits;
  localparam int nSets       = 2 ** setBits;
  localparam int clkPeriod   = 10;
  localparam int resetCycles = 10;
  localparam int idleCycles  = 20;
  localparam int numDirected = 26;
  localparam int numRandom   = 200;
  localparam int watchdogCycles =
    resetCycles + idleCycles + (numDirected + numRandom) * (memLatency + 10);

  // one row: test number, request, expected hit and load byte
  typedef struct packed {
    logic [2:0]         testId;
    cachePkg::cacheOp_e op;
    logic [31:0]        addr;
    logic [7:0]         wdata;
    logic               expHit;
    logic [7:0]         expByte;
  } stimEntry_t;

  logic               clk;
  logic               arstN;
  logic               reqValid;
  cachePkg::cacheOp_e reqOp;
  logic [31:0]        reqAddr;
  logic [31:0]        reqData;
  logic               respValid;
  logic [31:0]        respData;
  logic               respHit;

  stimEntry_t stimTable [numDirected];
  int fillIdx    = 0;
  int errorCount = 0;
  int checkCount = 0;

  // reference model
  logic [7:0]         shadowMem [2 ** (memWordBits + 2)];  // byte view of main memory
  logic [1:0]         modelValid [nSets];
  logic [tagBits-1:0] modelTag [nSets][2];
  logic [nSets-1:0]   modelLru;  // last touched way per set

  dataCache #(.setBits(setBits), .memLatency(memLatency), .memWordBits(memWordBits)) uut (
    .clk, .arstN, .reqValid, .reqOp, .reqAddr, .reqData, .respValid, .respData, .respHit
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(watchdogCycles * clkPeriod);
    $display("watchdog expired: the cache did not answer a request in time");
    $display("Done: errors found");
    $finish;
  end

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic addEntry(input logic [2:0] testId, input cachePkg::cacheOp_e op,
                          input logic [31:0] addr, input logic [7:0] wdata,
                          input logic expHit, input logic [7:0] expByte);
    stimTable[fillIdx] = '{testId, op, addr, wdata, expHit, expByte};
    fillIdx++;
  endtask

  task automatic fillTable();
    addEntry(1, cachePkg::opLoad,  32'h000, 8'h00, 1'b0, 8'h00);
    addEntry(1, cachePkg::opLoad,  32'h3e1, 8'h00, 1'b0, 8'h00);  // set 0, tag 31
    addEntry(2, cachePkg::opStore, 32'h024, 8'h5a, 1'b0, 8'h00);
    addEntry(2, cachePkg::opLoad,  32'h024, 8'h00, 1'b0, 8'h5a);
    addEntry(2, cachePkg::opLoad,  32'h024, 8'h00, 1'b1, 8'h5a);
    addEntry(3, cachePkg::opStore, 32'h048, 8'h11, 1'b0, 8'h00);
    addEntry(3, cachePkg::opStore, 32'h049, 8'h22, 1'b0, 8'h00);
    addEntry(3, cachePkg::opStore, 32'h04a, 8'h33, 1'b0, 8'h00);
    addEntry(3, cachePkg::opStore, 32'h04b, 8'h44, 1'b0, 8'h00);
    addEntry(3, cachePkg::opLoad,  32'h048, 8'h00, 1'b0, 8'h11);
    addEntry(3, cachePkg::opLoad,  32'h049, 8'h00, 1'b1, 8'h22);
    addEntry(3, cachePkg::opLoad,  32'h04a, 8'h00, 1'b1, 8'h33);
    addEntry(3, cachePkg::opLoad,  32'h04b, 8'h00, 1'b1, 8'h44);
    // set 3: A = 0x00c, B = 0x02c, C = 0x04c
    addEntry(4, cachePkg::opStore, 32'h04e, 8'h77, 1'b0, 8'h00);
    addEntry(4, cachePkg::opLoad,  32'h00c, 8'h00, 1'b0, 8'h00);
    addEntry(4, cachePkg::opLoad,  32'h02c, 8'h00, 1'b0, 8'h00);
    addEntry(4, cachePkg::opLoad,  32'h00c, 8'h00, 1'b1, 8'h00);
    addEntry(4, cachePkg::opLoad,  32'h04e, 8'h00, 1'b0, 8'h77);  // evicts B
    addEntry(4, cachePkg::opLoad,  32'h00c, 8'h00, 1'b1, 8'h00);
    addEntry(4, cachePkg::opLoad,  32'h02c, 8'h00, 1'b0, 8'h00);
    addEntry(5, cachePkg::opLoad,  32'h091, 8'h00, 1'b0, 8'h00);
    addEntry(5, cachePkg::opStore, 32'h091, 8'hc3, 1'b1, 8'h00);
    addEntry(5, cachePkg::opLoad,  32'h091, 8'h00, 1'b1, 8'hc3);
    addEntry(5, cachePkg::opLoad,  32'h0b0, 8'h00, 1'b0, 8'h00);
    addEntry(5, cachePkg::opLoad,  32'h0d0, 8'h00, 1'b0, 8'h00);
    addEntry(5, cachePkg::opLoad,  32'h091, 8'h00, 1'b0, 8'hc3);  // refetched from memory
  endtask

  task automatic modelAccess(input cachePkg::cacheOp_e op, input logic [31:0] addr,
                             input logic [7:0] wdata, output logic expHit,
                             output logic [7:0] expByte);
    logic [setBits-1:0] setIdx;
    logic [tagBits-1:0] tag;
    logic               hitW;
    logic               vic;
    setIdx = addr[cachePkg::offsetBits +: setBits];
    tag    = addr[31 -: tagBits];
    expHit = 1'b0;
    hitW   = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (modelValid[setIdx][w] && modelTag[setIdx][w] == tag) begin
        expHit = 1'b1;
        hitW   = w[0];
      end
    end
    expByte = shadowMem[addr[memWordBits+1:0]];
    if (op == cachePkg::opStore) shadowMem[addr[memWordBits+1:0]] = wdata;
    if (expHit) begin
      modelLru[setIdx] = hitW;
    end else if (op == cachePkg::opLoad) begin
      vic = ~modelLru[setIdx];  // least recently used way
      modelValid[setIdx][vic] = 1'b1;
      modelTag[setIdx][vic]   = tag;
      modelLru[setIdx]        = vic;
    end
  endtask

  // one request, returns the response and the edge count to respValid
  task automatic doRequest(input cachePkg::cacheOp_e op, input logic [31:0] addr,
                           input logic [7:0] wdata, output logic [31:0] data,
                           output logic hit, output int cycles);
    reqValid = 1'b1;
    reqOp    = op;
    reqAddr  = addr;
    reqData  = {24'h5a5a5a, wdata};  // upper bits ignored
    cycles   = 1;
    @(negedge clk);
    reqValid = 1'b0;
    while (!respValid) begin
      @(negedge clk);
      cycles++;
    end
    data = respData;
    hit  = respHit;
    @(negedge clk);
    checkValue(respValid, 0, "respValid longer than one cycle");
  endtask

  task automatic applyRequest(input cachePkg::cacheOp_e op, input logic [31:0] addr,
                              input logic [7:0] wdata, input logic expHit,
                              input logic [7:0] expByte);
    logic [31:0] data;
    logic        hit;
    int          cycles;
    int          expCycles;
    string       kind;
    kind = (op == cachePkg::opLoad) ? "load" : "store";
    doRequest(op, addr, wdata, data, hit, cycles);
    expCycles = (op == cachePkg::opLoad && !expHit) ? memLatency + 3 : 2;
    checkValue(hit, expHit, $sformatf("respHit of %s at %0h", kind, addr));
    checkValue(cycles, expCycles, $sformatf("latency of %s at %0h", kind, addr));
    if (op == cachePkg::opLoad) begin
      checkValue(data, {24'h0, expByte}, $sformatf("respData of load at %0h", addr));
    end
  endtask

  task automatic reportTest(input int testId, input int errs);
    string name;
    case (testId)
      1:       name = "reset and cold loads";
      2:       name = "write-through and refill";
      3:       name = "lane selection";
      4:       name = "LRU replacement";
      5:       name = "store hit";
      default: name = "random mix";
    endcase
    if (errs == 0) $display("test %0d %s: passed", testId, name);
    else $display("test %0d %s: failed with %0d errors", testId, name, errs);
  endtask

  initial begin
    logic               mHit;
    logic [7:0]         mByte;
    int                 errBefore;
    cachePkg::cacheOp_e rOp;
    logic [31:0]        rAddr;
    logic [7:0]         rData;
    void'($urandom(32'h7a2e_0729));
    arstN    = 1'b0;
    reqValid = 1'b0;
    reqOp    = cachePkg::opLoad;
    reqAddr  = '0;
    reqData  = '0;
    for (int i = 0; i < 2 ** (memWordBits + 2); i++) shadowMem[i] = '0;
    for (int i = 0; i < nSets; i++) modelValid[i] = '0;
    modelLru = '0;
    fillTable();
    repeat (resetCycles) @(negedge clk);
    arstN = 1'b1;

    for (int t = 1; t <= 5; t++) begin
      errBefore = errorCount;
      if (t == 1) begin
        repeat (idleCycles) begin  // quiet bus after reset
          @(negedge clk);
          checkValue(respValid, 0, "respValid with no request");
        end
      end
      for (int i = 0; i < numDirected; i++) begin
        if (stimTable[i].testId == t) begin
          modelAccess(stimTable[i].op, stimTable[i].addr, stimTable[i].wdata, mHit, mByte);
          applyRequest(stimTable[i].op, stimTable[i].addr, stimTable[i].wdata,
                       stimTable[i].expHit, stimTable[i].expByte);
        end
      end
      reportTest(t, errorCount - errBefore);
    end

    errBefore = errorCount;
    for (int n = 0; n < numRandom; n++) begin
      rOp   = cachePkg::cacheOp_e'($urandom_range(1, 0));
      rAddr = $urandom_range(255, 0);  // 8 tags per set
      rData = $urandom_range(255, 0);
      modelAccess(rOp, rAddr, rData, mHit, mByte);
      applyRequest(rOp, rAddr, rData, mHit, mByte);
    end
    reportTest(6, errorCount - errBefore);

    $display("6 tests, %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
source/cachePkg.sv
source/cacheWay.sv
source/wayMerge.sv
source/cacheCtrl.sv
source/mainMemory.sv
source/dataCache.sv
tb/dataCacheTb.sv

// File: Bender.yml
package:
  name: data_cache

sources:
  - source/cachePkg.sv
  - source/cacheWay.sv
  - source/wayMerge.sv
  - source/cacheCtrl.sv
  - source/mainMemory.sv
  - source/dataCache.sv
  - target: test
    files:
      - tb/dataCacheTb.sv
